/* Makefile */
# Verilator build, run and lint for the TCP transmit queue

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_tcp_tx_queue
RTL_TOP   ?= tcp_tx_queue
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from awk, set only when the pass line shows up
run: build
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* project.f */
+incdir+src
src/tcp_conn_pkg.sv
src/tcp_queue_pkg.sv
src/tcp_data_buf.sv
src/tcp_pkt_info_ram.sv
src/tcp_pkt_builder.sv
src/tcp_queue_ctrl.sv
src/tcp_tx_queue.sv
sim/tb_tcp_tx_queue.sv

/* sim/tb_tcp_tx_queue.sv */
//*********************************************************************
// TCP transmit queue testbench
// table-driven payload stimulus, a transmitter model answering offers,
// a sequence and checksum reference, compare tasks per result kind
//*********************************************************************
`timescale 1ns/1ps
`include "tcp_queue_macros.svh"

module tb_tcp_tx_queue;
  import tcp_conn_pkg::*;
  import tcp_queue_pkg::*;

  localparam int          AW             = `TXQ_DATA_AW;
  localparam logic [31:0] ISN            = 32'h1000;
  localparam int          RETRANS_CYCLES = `TXQ_RETRANS_TICKS * `TXQ_PKT_SLOTS * 5; // full laps
  localparam int          QUIET          = 2 * RETRANS_CYCLES;
  localparam int          HOLD           = 12; // extra busy cycles before tx_done
  localparam int          N_TESTS        = 5;

  typedef enum logic [1:0] {by_idle, by_snd, by_full} close_e;

  typedef struct packed {
    logic [7:0] nbytes;
    close_e     how;
    logic [3:0] pieces;    // equal parts, each closed on its own
    logic [3:0] rounds;    // offers expected per packet before the ack
    logic       ack;       // ack everything at the end, else flush
    logic       hold_done; // transmitter sits on tx_done for a while
  } test_t;

  string test_name [N_TESTS] = '{"idle5", "burst20", "snd3", "retry4", "fill8"};
  test_t tests [N_TESTS] = '{
    '{8'd5,  by_idle, 4'd1, 4'd1, 1'b1, 1'b0},
    '{8'd20, by_full, 4'd1, 4'd1, 1'b1, 1'b0}, // splits 16 + 4
    '{8'd6,  by_snd,  4'd2, 4'd1, 1'b1, 1'b1}, // two packets of 3 sent back to back
    '{8'd4,  by_idle, 4'd1, 4'd3, 1'b1, 1'b0}, // first offer plus two retries
    '{8'd16, by_snd,  4'd8, 4'd1, 1'b0, 1'b0}  // one packet per slot
  };

  logic                clk = 1'b0;
  logic                rst;
  logic [7:0]          in_d;
  logic                in_v, cts, snd, connected;
  logic                tx_busy, tx_done, pending, force_fin;
  logic                flush_queue, queue_flushed;
  logic [AW-1:0]       addr;
  logic [7:0]          data;
  tcb_t                tcb;
  tx_req_t             tx_req;

  logic [7:0]  exp_mem [0:`TXQ_DATA_SIZE-1]; // bytes sent, by low seq bits
  tx_req_t     offers [$];                    // as seen by the transmitter model
  tx_req_t     exp_q [$];                     // packets of the current test
  logic [31:0] next_seq  = ISN;
  int          errors    = 0;
  int          seed      = 32'h9b13a9b4;
  logic        hold_done = 1'b0;
  logic        ff_exp    = 1'b0;              // force_fin stays up once raised
  string       cur_name  = "reset";

  always #4 clk = ~clk;

  tcp_tx_queue i_dut (
    .clk(clk), .rst(rst), .in_d(in_d), .in_v(in_v), .cts(cts), .snd(snd),
    .tcb(tcb), .connected(connected), .tx_busy(tx_busy), .tx_done(tx_done),
    .addr(addr), .data(data), .pending(pending), .tx_req(tx_req),
    .force_fin(force_fin), .flush_queue(flush_queue), .queue_flushed(queue_flushed)
  );

  task automatic tick();
    @(posedge clk);
    #1; // drive and sample clear of the edge
  endtask

  task automatic check_req(input string what, input tx_req_t exp, input tx_req_t got);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: expected seq %h len %0d chsum %h, actual seq %h len %0d chsum %h",
               what, exp.seq, exp.len, exp.chsum, got.seq, got.len, got.chsum);
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", what, exp, got);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", what, exp, got);
    end
  endtask

  // big-endian 16-bit words, odd tail byte in the high half
  function automatic logic [31:0] word_sum(input logic [31:0] start, input int len);
    logic [31:0] sum;
    logic [31:0] a;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      a = start + 32'(i);
      sum += i[0] ? {24'h0, exp_mem[a[AW-1:0]]} : {16'h0, exp_mem[a[AW-1:0]], 8'h00};
    end
    return sum;
  endfunction

  // bytes, close waits and retransmit rounds of every test, plus margin
  function automatic int cycle_limit();
    int budget;
    budget = 16;
    foreach (tests[i]) begin
      budget += int'(tests[i].nbytes) + int'(tests[i].pieces) * (`TXQ_WAIT_TICKS + 8);
      budget += int'(tests[i].rounds) * RETRANS_CYCLES + QUIET;
    end
    return budget + 4 * RETRANS_CYCLES;
  endfunction

  task automatic send_piece(input int len, input close_e how);
    logic [31:0] start;
    int          chunk;
    start = next_seq;
    while (!cts) tick();
    for (int i = 0; i < len; i++) begin
      in_d = 8'($random(seed));
      in_v = 1'b1;
      exp_mem[next_seq[AW-1:0]] = in_d;
      next_seq++;
      tick();
    end
    in_v = 1'b0;
    if (how == by_snd) begin
      snd = 1'b1; // one-cycle send request
      tick();
      snd = 1'b0;
    end
    // continuous input closes at max payload, the tail by idle or snd
    for (int done = 0; done < len; done += chunk) begin
      chunk = (len - done > `TXQ_MAX_PAYLOAD) ? `TXQ_MAX_PAYLOAD : len - done;
      exp_q.push_back('{seq: start + 32'(done), len: len_t'(chunk),
                        chsum: word_sum(start + 32'(done), chunk)});
    end
    repeat ((how == by_snd) ? 2 : `TXQ_WAIT_TICKS + 4) tick();
  endtask

  // offers may come in any slot order, match them by seq
  task automatic collect_offers();
    int idx;
    while (offers.size() < exp_q.size()) tick();
    foreach (exp_q[e]) begin
      idx = 0;
      foreach (offers[k]) begin
        if (offers[k].seq == exp_q[e].seq) idx = k;
      end
      check_req({cur_name, " offer"}, exp_q[e], offers[idx]);
    end
    offers.delete();
  endtask

  task automatic run_flush();
    flush_queue = 1'b1;
    while (!queue_flushed) tick();
    tick();
    check_flag({cur_name, " queue_flushed pulse"}, 1'b0, queue_flushed); // single cycle
    repeat (4) tick();
    flush_queue = 1'b0;
    repeat (4) tick();
    check_flag({cur_name, " cts after flush"}, 1'b1, cts);
  endtask

  // transmitter: take the offer, read len bytes, then tx_done
  initial begin : tx_model
    tx_req_t     req;
    logic [31:0] a;
    tx_busy = 1'b0;
    tx_done = 1'b0;
    addr    = '0;
    forever begin
      tick();
      if (pending) begin
        req = tx_req;
        offers.push_back(req);
        tx_busy = 1'b1;
        for (int i = 0; i < int'(req.len); i++) begin
          a    = req.seq + 32'(i);
          addr = a[AW-1:0];
          tick(); // data one cycle after addr
          check_byte({cur_name, " payload"}, exp_mem[a[AW-1:0]], data);
        end
        if (hold_done) begin
          repeat (HOLD) begin
            tick();
            check_flag({cur_name, " pending held"}, 1'b1, pending);
            check_req({cur_name, " request held"}, req, tx_req);
          end
        end
        tx_done = 1'b1;
        tick();
        tx_done = 1'b0;
        tx_busy = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    int cycles;
    limit  = cycle_limit();
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests still running after %0d cycles", limit);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    test_t t;
    int    fails_before;
    int    test_fails;
    test_fails      = 0;
    rst             = 1'b1;
    in_d            = '0;
    in_v            = 1'b0;
    snd             = 1'b0;
    connected       = 1'b1;
    flush_queue     = 1'b0;
    tcb.loc_seq_num = ISN;
    tcb.rem_ack_num = ISN; // nothing outstanding yet
    repeat (5) tick();
    rst = 1'b0;
    repeat (4) tick(); // connection reset is registered once more
    check_flag("cts after reset", 1'b1, cts);
    for (int n = 0; n < N_TESTS; n++) begin
      t            = tests[n];
      cur_name     = test_name[n];
      hold_done    = t.hold_done;
      fails_before = errors;
      exp_q.delete();
      for (int p = 0; p < int'(t.pieces); p++) begin
        send_piece(int'(t.nbytes) / int'(t.pieces), t.how);
      end
      for (int r = 0; r < int'(t.rounds); r++) begin
        collect_offers();
        if (r == `TXQ_RETRANS_TRIES) ff_exp = 1'b1; // offer made with tries at the limit
        check_flag({cur_name, " force_fin"}, ff_exp, force_fin);
      end
      if (t.ack) begin
        tcb.rem_ack_num = next_seq; // covers every packet so far
      end else begin
        check_flag({cur_name, " cts with table full"}, 1'b0, cts);
        run_flush();
      end
      repeat (QUIET) tick();
      check_flag({cur_name, " offer after ack or flush"}, 1'b0, offers.size() != 0);
      offers.delete();
      if (errors == fails_before) begin
        $display("test %s: ok", cur_name);
      end else begin
        test_fails++;
        $display("test %s: %0d errors", cur_name, errors - fails_before);
      end
    end
    $display("%0d tests, %0d failed, %0d check errors", N_TESTS, test_fails, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_tcp_tx_queue

/* src/tcp_conn_pkg.sv */
//*********************************************************************
// TCP connection types
// values handed from connection management to the transmit path
//*********************************************************************
package tcp_conn_pkg;

  // 32-bit tcp sequence space, wraps freely
  typedef logic [31:0] seq_num_t;

  // transmission control block fields seen by the tx queue
  typedef struct packed {
    seq_num_t loc_seq_num; // initial local sequence
    seq_num_t rem_ack_num; // latest ack from remote
  } tcb_t;

endpackage : tcp_conn_pkg

/* src/tcp_data_buf.sv */
//*********************************************************************
// TCP raw payload buffer
// circular byte RAM written in sequence order, freed by the ack
// of the last released packet, read back by the transmitter
//*********************************************************************
`timescale 1ns/1ps
`include "tcp_queue_macros.svh"

module tcp_data_buf (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_v,
  input  logic [7:0]              wr_d,
  input  logic [31:0]             seq,     // next seq to be written
  input  logic [31:0]             isn,
  input  logic [31:0]             ack,     // everything before this is free
  input  logic [`TXQ_DATA_AW-1:0] rd_addr,
  output logic [7:0]              rd_q,
  output logic                    full
);

  logic [7:0]              mem [0:`TXQ_DATA_SIZE-1];
  logic [`TXQ_DATA_AW-1:0] wr_ptr;
  logic [31:0]             used;  // bytes held and not yet acked
  logic [31:0]             space;

  assign used  = seq - ack;
  assign space = 32'(`TXQ_DATA_SIZE) - used;
  assign full  = space[31] || (space == 32'h0); // negative counts as full too

  // write pointer tracks low bits of seq
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= isn[`TXQ_DATA_AW-1:0];
    end else if (wr_v) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_v) begin
      mem[wr_ptr] <= wr_d;
    end
  end

  always_ff @(posedge clk) begin
    rd_q <= mem[rd_addr]; // one cycle read latency
  end

endmodule : tcp_data_buf

/* src/tcp_pkt_builder.sv */
//*********************************************************************
// TCP packet builder
// counts payload bytes, sums 16-bit words and closes a packet on
// idle timeout, max length, full buffer or send request
//*********************************************************************
`timescale 1ns/1ps
`include "tcp_queue_macros.svh"

module tcp_pkt_builder (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush,
  input  logic [7:0]                in_d,
  input  logic                      in_v,
  input  logic                      snd,
  input  logic [31:0]               isn,
  input  logic [`TXQ_PKT_AW:0]      free_ptr,
  input  logic                      buf_full,
  output logic [31:0]               cur_seq,
  output tcp_queue_pkg::pkt_info_t  new_pkt,
  output logic [`TXQ_PKT_AW-1:0]    new_addr,
  output logic                      load,
  output logic                      build_busy,
  output logic                      slots_full
);
  import tcp_queue_pkg::*;

  build_state_e                          state;
  len_t                                  ctr;      // bytes in open packet
  logic [$clog2(`TXQ_WAIT_TICKS + 1)-1:0] idle_cnt;
  logic [31:0]                           chsum;    // complete word pairs only
  logic [7:0]                            odd_byte; // high byte waiting for its pair
  logic [`TXQ_PKT_AW:0]                  slot_ptr;
  logic [`TXQ_PKT_AW:0]                  occ;
  logic                                  close;
  logic                                  open_pkt;

  assign occ        = slot_ptr - free_ptr;
  assign slots_full = occ[`TXQ_PKT_AW]; // whole table ahead of the free pointer
  assign new_addr   = slot_ptr[`TXQ_PKT_AW-1:0];

  // no close while a load is in flight or no slot is left
  assign close = (state == build_collect) && !load && !slots_full &&
                 ((idle_cnt == `TXQ_WAIT_TICKS) || (ctr == `TXQ_MAX_PAYLOAD) ||
                  buf_full || snd);
  assign open_pkt   = in_v && ((state == build_idle) || close); // byte starts a packet
  assign build_busy = close || load;

  always_ff @(posedge clk) begin
    if (rst) begin
      cur_seq <= isn;
    end else if (in_v) begin
      cur_seq <= cur_seq + 32'd1;
    end
  end

  // word sum, big-endian pairs
  always_ff @(posedge clk) begin
    if (open_pkt) begin
      chsum    <= '0;
      odd_byte <= in_d;
    end else if (in_v) begin
      if (ctr[0]) chsum <= chsum + {16'h0, odd_byte, in_d};
      else        odd_byte <= in_d;
    end
  end

  // entry snapshot, written into the table one cycle later
  always_ff @(posedge clk) begin
    if (close) begin
      new_pkt.present <= 1'b1;
      new_pkt.start   <= cur_seq - 32'(ctr);
      new_pkt.stop    <= cur_seq;  // expected ack
      new_pkt.length  <= ctr;
      new_pkt.chsum   <= chsum + (ctr[0] ? {16'h0, odd_byte, 8'h00} : 32'h0);
      new_pkt.timer   <= timer_t'(`TXQ_RETRANS_TICKS); // first offer goes out at once
      new_pkt.tries   <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state    <= build_idle;
      ctr      <= '0;
      idle_cnt <= '0;
      load     <= 1'b0;
      slot_ptr <= '0;
    end else begin
      load <= close;
      if (load) slot_ptr <= slot_ptr + 1'b1;
      if (open_pkt) begin
        state    <= build_collect;
        ctr      <= len_t'(1);
        idle_cnt <= '0;
      end else if (close) begin
        state    <= build_idle;
        ctr      <= '0;
        idle_cnt <= '0;
      end else if (state == build_collect) begin
        if (in_v) begin
          ctr      <= ctr + 1'b1;
          idle_cnt <= '0; // any byte restarts the wait
        end else if (idle_cnt != `TXQ_WAIT_TICKS) begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

endmodule : tcp_pkt_builder

/* src/tcp_pkt_info_ram.sv */
//*********************************************************************
// TCP packet-info table
// add port written by the builder, update port read and written
// by the scan controller, both reads registered
//*********************************************************************
`timescale 1ns/1ps
`include "tcp_queue_macros.svh"

module tcp_pkt_info_ram (
  input  logic                      clk,
  input  logic                      load,
  input  logic [`TXQ_PKT_AW-1:0]    new_addr,
  input  tcp_queue_pkg::pkt_info_t  new_pkt,
  input  logic                      upd,
  input  logic [`TXQ_PKT_AW-1:0]    upd_addr,
  input  tcp_queue_pkg::pkt_info_t  upd_pkt,
  output tcp_queue_pkg::pkt_info_t  upd_q
);
  import tcp_queue_pkg::*;

  pkt_info_t tbl [0:`TXQ_PKT_SLOTS-1];

  // every slot starts absent
  initial begin
    for (int i = 0; i < `TXQ_PKT_SLOTS; i++) begin
      tbl[i] = '0;
    end
  end

  // both writes in one process, builder and controller never hit one slot
  always @(posedge clk) begin
    if (load) begin
      tbl[new_addr] <= new_pkt;
    end
    if (upd) begin
      tbl[upd_addr] <= upd_pkt;
      upd_q         <= upd_pkt; // write-through on update
    end else begin
      upd_q <= tbl[upd_addr];
    end
  end

endmodule : tcp_pkt_info_ram

/* src/tcp_queue_ctrl.sv */
//*********************************************************************
// TCP queue scan controller
// walks the packet-info table, frees acked entries in order, offers
// expired ones to the transmitter and clears the table on flush
//*********************************************************************
`timescale 1ns/1ps
`include "tcp_queue_macros.svh"

module tcp_queue_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush_queue,
  input  logic [31:0]               rem_ack,
  input  logic [31:0]               rst_ack,
  input  tcp_queue_pkg::pkt_info_t  upd_q,
  input  logic                      build_busy,
  input  logic                      tx_busy,
  input  logic                      tx_done,
  output logic                      upd,
  output logic [`TXQ_PKT_AW-1:0]    upd_addr,
  output tcp_queue_pkg::pkt_info_t  upd_pkt,
  output logic [31:0]               free_ack,
  output logic [`TXQ_PKT_AW:0]      free_ptr,
  output tcp_queue_pkg::tx_req_t    tx_req,
  output logic                      pending,
  output logic                      force_fin,
  output logic                      queue_flushed
);
  import tcp_queue_pkg::*;

  queue_state_e         state;
  pkt_info_t            cur;       // entry under inspection
  logic [31:0]          ack_diff;  // stop minus remote ack
  logic                 ack_done;
  logic                 acked;
  logic                 free_hit;
  logic                 retrans_hit;
  logic [`TXQ_PKT_AW:0] flush_ctr;

  assign ack_done = ack_diff[31] || (ack_diff == 32'h0); // zero or negative

  always_ff @(posedge clk) begin
    if (state == q_scan) begin
      cur      <= upd_q;
      ack_diff <= upd_q.stop - rem_ack;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= q_scan;
      upd           <= 1'b0;
      upd_addr      <= '0;
      free_ptr      <= '0;
      free_ack      <= rst_ack;
      pending       <= 1'b0;
      force_fin     <= 1'b0;
      queue_flushed <= 1'b0;
      flush_ctr     <= '0;
      acked         <= 1'b0;
      free_hit      <= 1'b0;
      retrans_hit   <= 1'b0;
    end else begin
      case (state)
        q_scan: begin // upd_q holds the slot at upd_addr
          queue_flushed <= 1'b0;
          if (flush_queue) begin
            state     <= q_flush;
            flush_ctr <= '0;
            free_ptr  <= '0;
            pending   <= 1'b0;
          end else if (upd_q.present) begin
            state <= q_read;
          end else begin
            upd_addr <= upd_addr + 1'b1;
            state    <= q_wait; // let the new read settle
          end
        end
        q_read: begin
          acked <= ack_done;
          // free only the oldest slot so free_ptr stays in step with the builder
          free_hit    <= ack_done && (upd_addr == free_ptr[`TXQ_PKT_AW-1:0]);
          retrans_hit <= !ack_done && (cur.timer == timer_t'(`TXQ_RETRANS_TICKS));
          state       <= q_check;
        end
        q_check: begin
          if (!tx_busy && !build_busy) begin // hold off transmitter and loads
            upd     <= 1'b1;
            upd_pkt <= cur;
            if (free_hit) begin
              upd_pkt <= '0;
              state   <= q_next;
            end else if (retrans_hit) begin
              upd_pkt.timer <= '0;
              upd_pkt.tries <= cur.tries + 1'b1;
              tx_req.seq    <= cur.start;
              tx_req.len    <= cur.length;
              tx_req.chsum  <= cur.chsum;
              pending       <= 1'b1;
              if (cur.tries == tries_t'(`TXQ_RETRANS_TRIES)) force_fin <= 1'b1;
              state <= q_retrans;
            end else begin
              if (!acked) upd_pkt.timer <= cur.timer + 1'b1; // acked but not oldest waits as is
              state <= q_next;
            end
          end
        end
        q_retrans: begin
          upd <= 1'b0; // entry write lands in this cycle
          if (tx_done) begin
            pending <= 1'b0;
            state   <= q_next;
          end
        end
        q_next: begin
          upd      <= 1'b0;
          upd_addr <= upd_addr + 1'b1;
          if (free_hit) begin
            free_ptr <= free_ptr + 1'b1;
            free_ack <= cur.stop; // release buffer up to this packet
          end
          state <= q_wait;
        end
        q_wait: begin
          state <= q_scan;
        end
        q_flush: begin
          upd_pkt <= '0;
          if (!flush_ctr[`TXQ_PKT_AW]) begin // one clear per slot
            upd_addr  <= flush_ctr[`TXQ_PKT_AW-1:0];
            upd       <= 1'b1;
            flush_ctr <= flush_ctr + 1'b1;
          end else if (upd) begin // last slot written this cycle
            upd           <= 1'b0;
            queue_flushed <= 1'b1;
          end else begin
            queue_flushed <= 1'b0;
            upd_addr      <= '0;
            if (!flush_queue) state <= q_wait; // hold until request drops
          end
        end
        default: begin
          state <= q_scan;
        end
      endcase
    end
  end

endmodule : tcp_queue_ctrl

/* src/tcp_queue_macros.svh */
//*********************************************************************
// TCP transmit queue sizes and limits
// shared by the queue packages and every queue module
//*********************************************************************
`ifndef TCP_QUEUE_MACROS_SVH
`define TCP_QUEUE_MACROS_SVH

`define TXQ_MAX_PAYLOAD   16  // bytes per packet before a forced close
`define TXQ_WAIT_TICKS    8   // idle cycles that close a partial packet
`define TXQ_RETRANS_TICKS 64  // scan visits between offers of an unacked packet
`define TXQ_RETRANS_TRIES 2   // offers allowed before force_fin

// raw payload buffer, 2^aw bytes
`define TXQ_DATA_AW   8
`define TXQ_DATA_SIZE (1 << `TXQ_DATA_AW)

// packet-info table, 2^aw slots
`define TXQ_PKT_AW    3
`define TXQ_PKT_SLOTS (1 << `TXQ_PKT_AW)

`define TXQ_LEN_W   16 // packet length field
`define TXQ_TIMER_W 7  // holds TXQ_RETRANS_TICKS
`define TXQ_TRIES_W 4

`endif

/* src/tcp_queue_pkg.sv */
//*********************************************************************
// TCP transmit queue types
// packet-info entry, transmit request and FSM state encodings
//*********************************************************************
`include "tcp_queue_macros.svh"

package tcp_queue_pkg;

  typedef logic [`TXQ_LEN_W-1:0]   len_t;
  typedef logic [`TXQ_TIMER_W-1:0] timer_t;
  typedef logic [`TXQ_TRIES_W-1:0] tries_t;

  // one slot of the packet-info table
  typedef struct packed {
    logic        present; // queued and not yet acked
    logic [31:0] start;   // seq of first byte
    logic [31:0] stop;    // ack expected for the whole packet
    len_t        length;  // bytes
    logic [31:0] chsum;   // unreduced sum of 16-bit payload words
    timer_t      timer;   // scan visits since last offer
    tries_t      tries;   // offers made so far
  } pkt_info_t;

  // packet offered to the transmitter
  typedef struct packed {
    logic [31:0] seq;
    len_t        len;
    logic [31:0] chsum;
  } tx_req_t;

  typedef enum logic {
    build_idle,
    build_collect
  } build_state_e;

  typedef enum logic [2:0] {
    q_scan, q_read, q_check, q_next, q_wait, q_retrans, q_flush
  } queue_state_e;

endpackage : tcp_queue_pkg

/* src/tcp_tx_queue.sv */
//*********************************************************************
// TCP transmit queue
// payload buffer, packet-info table, packet builder and scan
// controller behind one user and one transmitter interface
//*********************************************************************
`timescale 1ns/1ps
`include "tcp_queue_macros.svh"

module tcp_tx_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [7:0]              in_d,
  input  logic                    in_v,
  output logic                    cts,
  input  logic                    snd,
  input  tcp_conn_pkg::tcb_t      tcb,
  input  logic                    connected,
  input  logic                    tx_busy,
  input  logic                    tx_done,
  input  logic [`TXQ_DATA_AW-1:0] addr,
  output logic [7:0]              data,
  output logic                    pending,
  output tcp_queue_pkg::tx_req_t  tx_req,
  output logic                    force_fin,
  input  logic                    flush_queue,
  output logic                    queue_flushed
);
  import tcp_queue_pkg::*;

  logic                   connected_q;
  logic                   conn_rst;   // rst or connection edge
  pkt_info_t              new_pkt, upd_pkt, upd_q;
  logic [`TXQ_PKT_AW-1:0] new_addr, upd_addr;
  logic [`TXQ_PKT_AW:0]   free_ptr;
  logic [31:0]            cur_seq, free_ack;
  logic                   load, upd, build_busy, slots_full, buf_full;

  always_ff @(posedge clk) begin
    connected_q <= connected;
    conn_rst    <= rst || (connected_q != connected);
  end

  assign cts = connected && !slots_full && !buf_full;

  tcp_data_buf u_data_buf (
    .clk(clk), .rst(conn_rst), .wr_v(in_v), .wr_d(in_d),
    .seq(cur_seq), .isn(tcb.loc_seq_num), .ack(free_ack),
    .rd_addr(addr), .rd_q(data), .full(buf_full)
  );

  tcp_pkt_info_ram u_pkt_info_ram (
    .clk(clk), .load(load), .new_addr(new_addr), .new_pkt(new_pkt),
    .upd(upd), .upd_addr(upd_addr), .upd_pkt(upd_pkt), .upd_q(upd_q)
  );

  tcp_pkt_builder u_pkt_builder (
    .clk(clk), .rst(conn_rst), .flush(flush_queue),
    .in_d(in_d), .in_v(in_v), .snd(snd), .isn(tcb.loc_seq_num),
    .free_ptr(free_ptr), .buf_full(buf_full), .cur_seq(cur_seq),
    .new_pkt(new_pkt), .new_addr(new_addr), .load(load),
    .build_busy(build_busy), .slots_full(slots_full)
  );

  tcp_queue_ctrl u_queue_ctrl (
    .clk(clk), .rst(conn_rst), .flush_queue(flush_queue),
    .rem_ack(tcb.rem_ack_num), .rst_ack(tcb.rem_ack_num), .upd_q(upd_q),
    .build_busy(build_busy), .tx_busy(tx_busy), .tx_done(tx_done),
    .upd(upd), .upd_addr(upd_addr), .upd_pkt(upd_pkt),
    .free_ack(free_ack), .free_ptr(free_ptr), .tx_req(tx_req),
    .pending(pending), .force_fin(force_fin), .queue_flushed(queue_flushed)
  );

endmodule : tcp_tx_queue
